//--- logic/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// clock cycles per bit at the default clock and baud rate
`define UART_BAUD_DIV 434

// idle gap between the high and low frames of a write, in bit periods
`define UART_GAP_BITS 4

// how long a read waits for the response start bit, in bit periods
`define UART_RESP_TIMEOUT_BITS 32

`endif

//--- logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // bit 15 is the direction (1 = write), bits 14..8 the address, bits 7..0 the data
  typedef logic [15:0] cmd_t;
  typedef logic [7:0] byte_t;
  typedef logic [3:0] bit_cnt_t;  // bit position within a frame

  typedef enum logic [2:0] {
    tx_st_idle, tx_st_start, tx_st_data, tx_st_parity, tx_st_stop
  } tx_state_t;

  typedef enum logic [2:0] {
    rx_st_idle, rx_st_start, rx_st_data, rx_st_parity, rx_st_stop
  } rx_state_t;

  typedef enum logic [2:0] {
    cmd_st_idle,
    cmd_st_send_hi,
    cmd_st_gap,
    cmd_st_send_lo,
    cmd_st_wait_resp,
    cmd_st_finish
  } cmd_state_t;

endpackage

`default_nettype wire

//--- logic/uart_tx_frame.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_consts.svh"

module uart_tx_frame #(
  parameter int baud_div = `UART_BAUD_DIV
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           tx_start,
  input  uart_pkg::byte_t tx_data,
  output logic           tx,
  output logic           tx_done
);

  import uart_pkg::*;

  localparam int cnt_w = $clog2(baud_div);

  tx_state_t        state;
  logic [cnt_w-1:0] baud_cnt;
  bit_cnt_t         bit_idx;
  byte_t            shreg;
  logic             par;
  logic             bit_end;

  assign bit_end = (baud_cnt == cnt_w'(baud_div - 1));
  assign tx_done = (state == tx_st_stop) && bit_end;  // last cycle of the stop bit

  // --------------------------------------------------
  // frame sequencing
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= tx_st_idle;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      par      <= 1'b0;
    end
    else if (state == tx_st_idle)
    begin
      if (tx_start)
      begin
        state    <= tx_st_start;
        tx       <= 1'b0;  // start bit goes out on this edge
        baud_cnt <= '0;
        par      <= 1'b0;
      end
    end
    else if (!bit_end)
      baud_cnt <= baud_cnt + 1'b1;
    else
    begin
      baud_cnt <= '0;
      case (state)
        tx_st_start:
        begin
          state   <= tx_st_data;
          tx      <= shreg[0];
          bit_idx <= '0;
        end
        tx_st_data:
        begin
          par <= par ^ shreg[0];
          if (bit_idx == 4'd7)
          begin
            state <= tx_st_parity;
            tx    <= par ^ shreg[0];  // even parity over the eight data bits
          end
          else
          begin
            bit_idx <= bit_idx + 1'b1;
            tx      <= shreg[1];
          end
        end
        tx_st_parity:
        begin
          state <= tx_st_stop;
          tx    <= 1'b1;
        end
        default: state <= tx_st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == tx_st_idle && tx_start)
      shreg <= tx_data;
    else if (state == tx_st_data && bit_end)
      shreg <= shreg >> 1;  // next data bit moves to position 0
  end

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> state == tx_st_idle);

endmodule

`default_nettype wire

//--- logic/uart_rx_frame.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_consts.svh"

module uart_rx_frame #(
  parameter int baud_div = `UART_BAUD_DIV
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rx,
  output uart_pkg::byte_t rx_data,
  output logic            rx_valid,
  output logic            rx_err,
  output logic            rx_busy
);

  import uart_pkg::*;

  localparam int cnt_w = $clog2(baud_div);

  rx_state_t        state;
  logic [cnt_w-1:0] baud_cnt;
  bit_cnt_t         bit_idx;
  logic             rx_s1;
  logic             rx_s2;
  logic             rx_d;
  logic             par;
  logic             fall;
  logic             half_end;
  logic             bit_end;

  assign fall     = rx_d && !rx_s2;
  assign half_end = (baud_cnt == cnt_w'(baud_div / 2 - 1));
  assign bit_end  = (baud_cnt == cnt_w'(baud_div - 1));
  assign rx_busy  = (state != rx_st_idle);

  // two-flop synchronizer plus one more stage for edge detection
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  // --------------------------------------------------
  // frame capture
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= rx_st_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
      par      <= 1'b0;
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      rx_err   <= 1'b0;
      baud_cnt <= baud_cnt + 1'b1;
      case (state)
        rx_st_idle:
        begin
          baud_cnt <= '0;
          if (fall)
            state <= rx_st_start;
        end
        rx_st_start:
          if (half_end)
          begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            par      <= 1'b0;
            // a glitch that is gone by mid-bit is not a frame
            state    <= rx_s2 ? rx_st_idle : rx_st_data;
          end
        rx_st_data:
          if (bit_end)
          begin
            baud_cnt <= '0;
            par      <= par ^ rx_s2;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 4'd7)
              state <= rx_st_parity;
          end
        rx_st_parity:
          if (bit_end)
          begin
            baud_cnt <= '0;
            par      <= par ^ rx_s2;  // stays 0 when the parity is even
            state    <= rx_st_stop;
          end
        default:
          if (bit_end)
          begin
            state    <= rx_st_idle;
            rx_valid <= rx_s2 && !par;
            rx_err   <= !rx_s2 || par;
          end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == rx_st_data && bit_end)
      rx_data <= {rx_s2, rx_data[7:1]};  // lsb arrives first
  end

endmodule

`default_nettype wire

//--- logic/uart_cmd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_consts.svh"

module uart_cmd_ctrl #(
  parameter int baud_div = `UART_BAUD_DIV
) (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd_in,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  output logic            tx_start,
  output uart_pkg::byte_t tx_data,
  input  logic            tx_done,
  input  uart_pkg::byte_t rx_data,
  input  logic            rx_valid,
  input  logic            rx_err,
  input  logic            rx_busy,
  output uart_pkg::byte_t read_data,
  output logic            read_rdy,
  output logic            read_err
);

  import uart_pkg::*;

  localparam int gap_cycles  = `UART_GAP_BITS * baud_div;
  localparam int resp_cycles = `UART_RESP_TIMEOUT_BITS * baud_div;
  localparam int cnt_max     = (resp_cycles > gap_cycles) ? resp_cycles : gap_cycles;
  localparam int cnt_w       = $clog2(cnt_max + 1);

  cmd_state_t       state;
  cmd_t             cmd_q;
  logic [cnt_w-1:0] cnt;  // shared by the write gap and the response timeout
  logic             accept;
  logic             gap_end;
  logic             resp_timeout;

  assign accept       = cmd_vld && cmd_rdy;
  assign gap_end      = (cnt == cnt_w'(gap_cycles - 1));
  assign resp_timeout = (cnt == cnt_w'(resp_cycles - 1));

  // --------------------------------------------------
  // transaction sequencing
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= cmd_st_idle;
      cmd_rdy  <= 1'b1;
      cnt      <= '0;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        cmd_st_idle:
          if (accept)
          begin
            state    <= cmd_st_send_hi;
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
          end
        cmd_st_send_hi:
          if (tx_done)
          begin
            cnt   <= cnt_w'(1);  // the tx_done cycle counts as the first one
            state <= cmd_q[15] ? cmd_st_gap : cmd_st_wait_resp;
          end
        cmd_st_gap:
          if (gap_end)
          begin
            state    <= cmd_st_send_lo;
            tx_start <= 1'b1;
          end
          else
            cnt <= cnt + 1'b1;
        cmd_st_send_lo:
          if (tx_done)
            state <= cmd_st_finish;
        cmd_st_wait_resp:
          if (rx_valid)
          begin
            read_rdy <= 1'b1;
            state    <= cmd_st_finish;
          end
          else if (rx_err)
          begin
            read_err <= 1'b1;
            state    <= cmd_st_finish;
          end
          else if (!rx_busy)
          begin
            // a frame in progress holds the timeout off
            if (resp_timeout)
            begin
              read_err <= 1'b1;
              state    <= cmd_st_finish;
            end
            else
              cnt <= cnt + 1'b1;
          end
        default:
        begin
          state   <= cmd_st_idle;
          cmd_rdy <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd_in;
      tx_data <= cmd_in[15:8];
    end
    else if (state == cmd_st_gap && gap_end)
      tx_data <= cmd_q[7:0];
    if (state == cmd_st_wait_resp && rx_valid)
      read_data <= rx_data;
  end

  a_result_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_rdy && read_err));

  a_rdy_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state != cmd_st_idle) |-> !cmd_rdy);

endmodule

`default_nettype wire

//--- logic/uart_cmd_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_consts.svh"

module uart_cmd_top #(
  parameter int baud_div = `UART_BAUD_DIV
) (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd_in,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  input  logic            rx,
  output logic            tx,
  output uart_pkg::byte_t read_data,
  output logic            read_rdy,
  output logic            read_err
);

  import uart_pkg::*;

  logic  tx_start;
  logic  tx_done;
  byte_t tx_data;
  byte_t rx_data;
  logic  rx_valid;
  logic  rx_err;
  logic  rx_busy;

  uart_cmd_ctrl #(
    .baud_div (baud_div)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_data   (tx_data),
    .tx_done   (tx_done),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .rx_err    (rx_err),
    .rx_busy   (rx_busy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx_frame #(
    .baud_div (baud_div)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  // the receiver listens all the time and the sequencer filters by state
  uart_rx_frame #(
    .baud_div (baud_div)
  ) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_err   (rx_err),
    .rx_busy  (rx_busy)
  );

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter real period = 4.0
) (
  output logic clk
);

  initial
    clk = 1'b0;

  always #(period / 2.0) clk = ~clk;  // 50% duty cycle

endmodule

`default_nettype wire

//--- tb/uart_peer_model.sv
`timescale 1ns/100ps
`default_nettype none
`include "uart_consts.svh"

module uart_peer_model #(
  parameter int baud_div = `UART_BAUD_DIV
) (
  input  logic            clk,
  input  logic            tx,
  input  logic            corrupt_parity,
  input  logic            mute,
  output logic            rx,
  output logic            frame_vld,
  output logic            frame_err,
  output uart_pkg::byte_t frame_byte
);

  import uart_pkg::*;

  byte_t      regs [0:127];
  logic       wr_pending;  // a write's high byte has arrived and the data byte is due
  logic [6:0] wr_addr;

  // all sampling and driving happens 1 ns after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // called in the first cycle of the start bit
  task automatic decode_frame(output byte_t data, output logic err);
    logic par;
    data = '0;
    err  = 1'b0;
    wait_cycles(baud_div / 2);
    if (tx !== 1'b0)
      err = 1'b1;  // start bit did not last to its middle
    for (int i = 0; i < 8; i++)
    begin
      wait_cycles(baud_div);
      data[i] = tx;
    end
    wait_cycles(baud_div);
    par = tx;
    wait_cycles(baud_div);
    if (tx !== 1'b1 || (^data) !== par)
      err = 1'b1;
  endtask

  task automatic send_answer(input byte_t data, input logic flip);
    rx = 1'b0;
    wait_cycles(baud_div);
    for (int i = 0; i < 8; i++)
    begin
      rx = data[i];
      wait_cycles(baud_div);
    end
    rx = (^data) ^ flip;  // even parity unless told to break it
    wait_cycles(baud_div);
    rx = 1'b1;
    wait_cycles(baud_div);
  endtask

  // --------------------------------------------------
  // frame decoding and register access
  initial
  begin : peer_loop
    byte_t data;
    logic  err;
    for (int i = 0; i < 128; i++)
      regs[i] = byte_t'(i) ^ 8'h5a;
    rx         = 1'b1;
    frame_vld  = 1'b0;
    frame_err  = 1'b0;
    frame_byte = '0;
    wr_pending = 1'b0;
    wr_addr    = '0;
    forever
    begin
      wait_cycles(1);
      if (tx === 1'b0)
      begin
        decode_frame(data, err);
        frame_byte = data;
        frame_err  = err;
        frame_vld  = 1'b1;
        wait_cycles(1);
        frame_vld  = 1'b0;
        if (err)
          wr_pending = 1'b0;
        else if (wr_pending)
        begin
          regs[wr_addr] = data;
          wr_pending    = 1'b0;
        end
        else if (data[7])
        begin
          wr_pending = 1'b1;
          wr_addr    = data[6:0];
        end
        else if (!mute)
        begin
          // answer about two bit periods after the command frame
          wait_cycles(2 * baud_div - 1);
          send_answer(regs[data[6:0]], corrupt_parity);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/uart_cmd_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_tb;

  import uart_pkg::*;

  localparam int baud_div = 8;
  localparam int n_write  = 20;
  localparam int n_read   = 12;
  localparam int n_bad    = 3;
  localparam int n_mute   = 3;
  localparam int n_burst  = 10;
  // every corrupted read is followed by a clean read of the same address
  localparam int n_cmds      = n_write + n_read + 2 * n_bad + n_mute + n_burst;
  localparam int cycle_limit = n_cmds * 40 * baud_div;

  logic  clk;
  logic  rst_n;
  cmd_t  cmd_in;
  logic  cmd_vld;
  logic  cmd_rdy;
  logic  rx;
  logic  tx;
  byte_t read_data;
  logic  read_rdy;
  logic  read_err;
  logic  corrupt_parity;
  logic  mute;
  logic  frame_vld;
  logic  frame_err;
  byte_t frame_byte;

  byte_t       model [0:127];
  logic [31:0] rng;
  int          cycles;
  int          err_cnt;
  int          err_cycle;  // value of cycles during the last read_err pulse
  int          exp_err;
  logic [8:0]  frame_q[$];  // {frame error, byte} for each frame the peer decoded
  logic [8:0]  exp_frame_q[$];
  byte_t       read_q[$];
  byte_t       exp_read_q[$];
  logic [6:0]  written[$];

  tb_clock #(
    .period (4.0)
  ) u_clk (
    .clk (clk)
  );

  uart_cmd_top #(
    .baud_div (baud_div)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_peer_model #(
    .baud_div (baud_div)
  ) u_peer (
    .clk            (clk),
    .tx             (tx),
    .corrupt_parity (corrupt_parity),
    .mute           (mute),
    .rx             (rx),
    .frame_vld      (frame_vld),
    .frame_err      (frame_err),
    .frame_byte     (frame_byte)
  );

  function automatic logic [31:0] lcg_next();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // holds the command with cmd_vld high until the accepting edge has passed
  task automatic send_cmd(input cmd_t c);
    cmd_in  = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
      next_cycle();
    next_cycle();
    cmd_vld = 1'b0;
  endtask

  task automatic queue_cmd(input cmd_t c, input logic answered);
    exp_frame_q.push_back({1'b0, c[15:8]});
    if (c[15])
    begin
      exp_frame_q.push_back({1'b0, c[7:0]});
      model[c[14:8]] = c[7:0];
    end
    else if (answered)
      exp_read_q.push_back(model[c[14:8]]);
    send_cmd(c);
  endtask

  task automatic check_results(input string name);
    while (!cmd_rdy)
      next_cycle();
    check_eq($sformatf("%s frame count", name), exp_frame_q.size(), frame_q.size());
    while (exp_frame_q.size() > 0)
      check_eq($sformatf("%s frame", name), exp_frame_q.pop_front(), frame_q.pop_front());
    check_eq($sformatf("%s read count", name), exp_read_q.size(), read_q.size());
    while (exp_read_q.size() > 0)
      check_eq($sformatf("%s read data", name), exp_read_q.pop_front(), read_q.pop_front());
    check_eq($sformatf("%s read_err count", name), exp_err, err_cnt);
  endtask

  // results are picked up mid-cycle
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (read_rdy)
        read_q.push_back(read_data);
      if (read_err)
      begin
        err_cnt++;
        err_cycle = cycles;
      end
      if (frame_vld)
        frame_q.push_back({frame_err, frame_byte});
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("timeout: the run went past %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $fatal(1);
    end
  end

  initial
  begin : stimulus
    cmd_t        c;
    int          idx;
    logic [31:0] r;
    rng            = 32'hbb7c;
    cycles         = 0;
    err_cnt        = 0;
    err_cycle      = 0;
    exp_err        = 0;
    rst_n          = 1'b0;
    cmd_in         = '0;
    cmd_vld        = 1'b0;
    corrupt_parity = 1'b0;
    mute           = 1'b0;
    for (int i = 0; i < 128; i++)
      model[i] = byte_t'(i) ^ 8'h5a;  // same fill the peer starts from
    repeat (2)
      next_cycle();
    rst_n = 1'b1;
    next_cycle();

    check_eq("reset tx", 1, tx);
    check_eq("reset cmd_rdy", 1, cmd_rdy);
    check_eq("reset read_rdy", 0, read_rdy);
    check_eq("reset read_err", 0, read_err);

    // --------------------------------------------------
    // single writes, then reads of written addresses
    for (int i = 0; i < n_write; i++)
    begin
      r = lcg_next();
      c = {1'b1, r[22:16], r[30:23]};
      written.push_back(c[14:8]);
      queue_cmd(c, 1'b1);
      check_results("write");
    end
    for (int i = 0; i < n_read; i++)
    begin
      r   = lcg_next();
      idx = r % written.size();
      c   = {1'b0, written[idx], r[7:0]};
      queue_cmd(c, 1'b1);
      check_results("read");
    end

    // --------------------------------------------------
    // broken answers
    for (int i = 0; i < n_bad; i++)
    begin
      r   = lcg_next();
      idx = r % written.size();
      c   = {1'b0, written[idx], r[7:0]};
      corrupt_parity = 1'b1;
      exp_err++;
      queue_cmd(c, 1'b0);
      check_results("bad parity read");
      corrupt_parity = 1'b0;
      queue_cmd(c, 1'b1);  // register must still hold the model's value
      check_results("read after bad parity");
    end
    mute = 1'b1;
    for (int i = 0; i < n_mute; i++)
    begin
      r = lcg_next();
      c = {1'b0, r[22:16], r[7:0]};
      exp_err++;
      queue_cmd(c, 1'b0);
      check_results("muted read");
      // a read ends in the cycle right after its read_err pulse
      check_eq("muted read cmd_rdy cycle", err_cycle + 1, cycles);
    end
    mute = 1'b0;

    // --------------------------------------------------
    // back-to-back commands held while cmd_rdy is low
    for (int i = 0; i < n_burst; i++)
    begin
      r = lcg_next();
      if (r[0])
      begin
        c = {1'b1, r[22:16], r[30:23]};
        written.push_back(c[14:8]);
      end
      else
      begin
        idx = r % written.size();
        c   = {1'b0, written[idx], r[7:0]};
      end
      queue_cmd(c, 1'b1);
    end
    check_results("back-pressure");

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_tx_frame.sv
logic/uart_rx_frame.sv
logic/uart_cmd_ctrl.sv
logic/uart_cmd_top.sv
tb/tb_clock.sv
tb/uart_peer_model.sv
tb/uart_cmd_tb.sv
